//--- bench/mem_stage_input.txt
# columns (hex): op address store_data expected_ld_data expected_miss_align
# op: 0 nop, 1 lw, 2 lh, 3 lhu, 4 lb, 5 lbu, 6 sw
6 00000010 deadbeef 00000000 0
1 00000010 00000000 deadbeef 0
6 00000014 12348765 00000000 0
2 00000014 00000000 ffff8765 0
4 00000014 00000000 00000065 0
3 00000014 00000000 00008765 0
5 00000014 00000000 00000065 0
6 00000018 000074a5 00000000 0
2 00000018 00000000 000074a5 0
4 00000018 00000000 ffffffa5 0
5 00000018 00000000 000000a5 0
3 00000010 00000000 0000beef 0
6 00000011 55555555 00000000 1
1 00000012 00000000 00000000 1
5 00000017 00000000 00000000 1
0 00000010 ffffffff 00000000 0
1 00000010 00000000 deadbeef 0
6 00000100 11111111 00000000 0
6 000003fc 33333333 00000000 0
1 000003fc 00000000 33333333 0
1 00000100 00000000 11111111 0

//--- tb.f
+incdir+logic
logic/mem_stage_pkg.sv
logic/mem_ctrl.sv
logic/lsu_sequencer.sv
logic/data_ram.sv
logic/mem_stage_top.sv
bench/mem_stage_chk.sv
bench/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/10ps
TOP       := mem_stage_tb
FILELIST  := tb.f
LOG       := sim.log

SIM  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/mem_stage_tb.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int TIMEOUT = 50;                     // cycles per wait

    logic                   clk;
    logic                   arst_n;
    logic                   req;
    mem_op_e                mem_op;
    logic [31:0]            addr;
    logic [`DATA_WIDTH-1:0] wr_data;
    logic                   busy;
    logic                   done;
    logic [`DATA_WIDTH-1:0] ld_data;
    logic                   miss_align;
    int                     vec_num;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    mem_stage_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .mem_op     (mem_op),
        .addr       (addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done),
        .ld_data    (ld_data),
        .miss_align (miss_align)
    );

    bind mem_stage_top mem_stage_chk u_chk (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .ack    (ack),
        .wb_adr (wb_adr)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at vector %0d", vec_num);
    endtask

    task automatic check_data(input string name, input logic [`DATA_WIDTH-1:0] got,
                              input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s vector %0d: got %h, expected %h",
                                     name, vec_num, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s vector %0d: got %h, expected %h",
                                     name, vec_num, got, exp));
        end
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (busy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (busy) begin
            report_failure($sformatf("busy stayed high too long before vector %0d", vec_num));
        end
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        while (!done && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!done) begin
            report_failure($sformatf("done never came for vector %0d", vec_num));
        end
    endtask

    // one request, returns at the negedge inside the done cycle
    task automatic run_request(input mem_op_e op, input logic [31:0] a,
                               input logic [`DATA_WIDTH-1:0] d, input logic bus_exp);
        wait_idle();
        @(posedge clk);
        req     <= 1'b1;
        mem_op  <= op;
        addr    <= a;
        wr_data <= d;
        @(posedge clk);
        req     <= 1'b0;                             // accepted on this edge
        @(negedge clk);
        check_flag("busy", busy, bus_exp);           // high only while a bus cycle runs
        wait_done();
        check_flag("busy", busy, 1'b0);
    endtask

    initial begin
        string                  line;
        int                     fd;
        logic [2:0]             op_raw;
        logic [31:0]            a;
        logic [`DATA_WIDTH-1:0] d;
        logic [`DATA_WIDTH-1:0] exp_d;
        logic                   exp_m;
        logic                   bus_exp;
        arst_n  = 1'b0;
        req     = 1'b0;
        mem_op  = MEM_OP_NOP;
        addr    = '0;
        wr_data = '0;
        vec_num = 0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("bench/mem_stage_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the vector file bench/mem_stage_input.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", op_raw, a, d, exp_d, exp_m) == 5) begin
                    vec_num++;
                    bus_exp = (mem_op_e'(op_raw) != MEM_OP_NOP) && !exp_m;
                    run_request(mem_op_e'(op_raw), a, d, bus_exp);
                    check_flag("miss_align", miss_align, exp_m);
                    check_data("ld_data", ld_data, exp_d);
                end
            end
        end
        $fclose(fd);
        if (vec_num == 0) begin
            report_failure("the vector file held no requests");
        end
        repeat (2) @(posedge clk);                   // let the last assertions sample
        if (UUT.u_chk.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            report_failure("a bus protocol assertion failed during the run");
        end
        $finish;
    end

endmodule

//--- bench/mem_stage_chk.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module mem_stage_chk (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        req,
    input logic                        busy,
    input logic                        done,
    input logic                        cyc,
    input logic                        stb,
    input logic                        we,
    input logic                        ack,
    input logic [`WORD_ADDR_WIDTH-1:0] wb_adr
);

    int fail_cnt = 0;                                // read by the testbench

    no_req_while_busy: assert property (@(posedge clk) disable iff (!arst_n) busy |-> !req)
        else begin
            $error("request driven while busy");
            fail_cnt++;
        end

    // master ends the cycle right after it samples ack
    cyc_drops_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
                                          ack |=> (!cyc && !stb))
        else begin
            $error("cyc or stb still high after ack");
            fail_cnt++;
        end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n) ack |-> stb)
        else begin
            $error("ack outside a strobe");
            fail_cnt++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

    // address and direction frozen while the slave waits
    bus_stable: assert property (@(posedge clk) disable iff (!arst_n)
                                 (stb && !ack) |=> ($stable(we) && $stable(wb_adr)))
        else begin
            $error("we or wb_adr changed before ack");
            fail_cnt++;
        end

endmodule

//--- logic/mem_stage_top.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module mem_stage_top import mem_stage_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  mem_op_e                mem_op,
    input  logic [31:0]            addr,
    input  logic [`DATA_WIDTH-1:0] wr_data,
    output logic                   busy,
    output logic                   done,
    output logic [`DATA_WIDTH-1:0] ld_data,
    output logic                   miss_align
);

    mem_op_e                     op_q;
    logic [31:0]                 addr_q;
    logic [`DATA_WIDTH-1:0]      wdata_q;
    logic [`DATA_WIDTH-1:0]      rdata_q;
    logic                        mem_as_n;
    bus_dir_e                    rw;
    logic [`WORD_ADDR_WIDTH-1:0] addr_to_mem;
    logic [`DATA_WIDTH-1:0]      wr_data_to_mem;
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`WORD_ADDR_WIDTH-1:0] wb_adr;
    logic [`DATA_WIDTH-1:0]      wb_dat_w;
    logic [`DATA_WIDTH-1:0]      wb_dat_r;
    logic                        ack;

    lsu_sequencer u_seq (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .mem_op         (mem_op),
        .addr           (addr),
        .wr_data        (wr_data),
        .mem_as_n       (mem_as_n),
        .rw             (rw),
        .miss_align     (miss_align),
        .addr_to_mem    (addr_to_mem),
        .wr_data_to_mem (wr_data_to_mem),
        .wb_dat_r       (wb_dat_r),
        .ack            (ack),
        .busy           (busy),
        .done           (done),
        .op_q           (op_q),
        .addr_q         (addr_q),
        .wdata_q        (wdata_q),
        .rdata_q        (rdata_q),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w)
    );

    // decodes the held request
    mem_ctrl u_ctrl (
        .mem_op           (op_q),
        .mem_addr         (addr_q),
        .rd_data_from_mem (rdata_q),
        .mem_wr_data      (wdata_q),
        .rw               (rw),
        .addr_to_mem      (addr_to_mem),
        .wr_data          (wr_data_to_mem),
        .mem_data_to_gpr  (ld_data),
        .mem_as_n         (mem_as_n),
        .miss_align       (miss_align)
    );

    data_ram u_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .ack      (ack)
    );

endmodule

//--- logic/data_ram.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module data_ram (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [`WORD_ADDR_WIDTH-1:0] wb_adr,
    input  logic [`DATA_WIDTH-1:0]      wb_dat_w,
    output logic [`DATA_WIDTH-1:0]      wb_dat_r,
    output logic                        ack
);

    localparam int RAM_WORDS = 1 << `RAM_DEPTH_LOG2;
    localparam int WAIT_W    = $clog2(`RAM_WAIT_STATES + 2);

    logic [`DATA_WIDTH-1:0]    mem [0:RAM_WORDS-1];
    logic [WAIT_W-1:0]         wait_cnt;
    logic [`RAM_DEPTH_LOG2-1:0] ram_idx;
    logic                      wait_done;

    assign ram_idx   = wb_adr[`RAM_DEPTH_LOG2-1:0];   // upper bits ignored
    assign wait_done = (wait_cnt == WAIT_W'(`RAM_WAIT_STATES));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
            ack      <= 1'b0;
        end else if (ack) begin
            wait_cnt <= '0;                          // one ack per strobe
            ack      <= 1'b0;
        end else if (cyc && stb) begin
            if (wait_done) begin
                ack <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && stb && !ack && wait_done) begin
            wb_dat_r <= mem[ram_idx];                // valid together with ack
        end
        if (cyc && stb && we && ack) begin
            mem[ram_idx] <= wb_dat_w;
        end
    end

endmodule

//--- logic/lsu_sequencer.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module lsu_sequencer import mem_stage_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,
    input  mem_op_e                     mem_op,
    input  logic [31:0]                 addr,
    input  logic [`DATA_WIDTH-1:0]      wr_data,
    input  logic                        mem_as_n,       // from mem_ctrl
    input  bus_dir_e                    rw,
    input  logic                        miss_align,
    input  logic [`WORD_ADDR_WIDTH-1:0] addr_to_mem,
    input  logic [`DATA_WIDTH-1:0]      wr_data_to_mem,
    input  logic [`DATA_WIDTH-1:0]      wb_dat_r,
    input  logic                        ack,
    output logic                        busy,
    output logic                        done,
    output mem_op_e                     op_q,
    output logic [31:0]                 addr_q,
    output logic [`DATA_WIDTH-1:0]      wdata_q,
    output logic [`DATA_WIDTH-1:0]      rdata_q,
    output logic                        cyc,
    output logic                        stb,
    output logic                        we,
    output logic [`WORD_ADDR_WIDTH-1:0] wb_adr,
    output logic [`DATA_WIDTH-1:0]      wb_dat_w
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_FINISH
    } seq_state_e;

    seq_state_e state;
    logic       access_ok;
    logic       accept;

    // held request decodes to a real, aligned access
    assign access_ok = !mem_as_n && !miss_align;
    assign accept    = req && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            op_q   <= MEM_OP_NOP;
            addr_q <= '0;
        end else begin
            if (accept) begin
                state  <= ST_BUS;
                op_q   <= mem_op;
                addr_q <= addr;
            end else begin
                case (state)
                    ST_BUS: begin
                        if (!access_ok) begin
                            state <= ST_IDLE;       // nop or misaligned, no bus cycle
                        end else if (ack) begin
                            state <= ST_FINISH;
                        end
                    end
                    ST_FINISH: state <= ST_IDLE;
                    default:   state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wdata_q <= wr_data;
        end
        if (state == ST_BUS && ack) begin
            rdata_q <= wb_dat_r;                    // read word for formatting
        end
    end

    assign busy     = (state == ST_BUS) && access_ok;
    assign done     = (state == ST_FINISH) || (state == ST_BUS && !access_ok);
    assign cyc      = (state == ST_BUS) && access_ok;
    assign stb      = cyc;                          // single transfer per cycle
    assign we       = cyc && (rw == BUS_WRITE);
    assign wb_adr   = addr_to_mem;
    assign wb_dat_w = wr_data_to_mem;

endmodule

//--- logic/mem_ctrl.sv
`timescale 1ns/10ps
`include "mem_stage_config.svh"

module mem_ctrl import mem_stage_pkg::*; (
    input  mem_op_e                     mem_op,           // from decoder
    input  logic [31:0]                 mem_addr,         // byte address from alu
    input  logic [`DATA_WIDTH-1:0]      rd_data_from_mem, // captured read word
    input  logic [`DATA_WIDTH-1:0]      mem_wr_data,      // store data from gpr
    output bus_dir_e                    rw,
    output logic [`WORD_ADDR_WIDTH-1:0] addr_to_mem,
    output logic [`DATA_WIDTH-1:0]      wr_data,
    output logic [`DATA_WIDTH-1:0]      mem_data_to_gpr,
    output logic                        mem_as_n,         // access strobe, active low
    output logic                        miss_align
);

    localparam int HALF_W = `DATA_WIDTH / 2;
    localparam int BYTE_W = 8;

    logic [1:0]             offset;
    logic                   aligned;
    logic [`DATA_WIDTH-1:0] half_sext;
    logic [`DATA_WIDTH-1:0] half_zext;
    logic [`DATA_WIDTH-1:0] byte_sext;
    logic [`DATA_WIDTH-1:0] byte_zext;

    assign offset      = mem_addr[1:0];
    assign aligned     = (offset == 2'b00);
    assign addr_to_mem = mem_addr[`WORD_ADDR_WIDTH+1:2]; // drop byte offset
    assign wr_data     = mem_wr_data;                    // stores are whole words

    // low halfword / low byte of the word, both extensions
    assign half_sext = {{(`DATA_WIDTH-HALF_W){rd_data_from_mem[HALF_W-1]}},
                        rd_data_from_mem[HALF_W-1:0]};
    assign half_zext = {{(`DATA_WIDTH-HALF_W){1'b0}}, rd_data_from_mem[HALF_W-1:0]};
    assign byte_sext = {{(`DATA_WIDTH-BYTE_W){rd_data_from_mem[BYTE_W-1]}},
                        rd_data_from_mem[BYTE_W-1:0]};
    assign byte_zext = {{(`DATA_WIDTH-BYTE_W){1'b0}}, rd_data_from_mem[BYTE_W-1:0]};

    always_comb begin
        mem_as_n        = 1'b1;
        rw              = BUS_READ;
        miss_align      = 1'b0;
        mem_data_to_gpr = '0;
        case (mem_op)
            MEM_OP_LW: begin
                mem_as_n   = 1'b0;
                miss_align = !aligned;
                if (aligned) begin
                    mem_data_to_gpr = rd_data_from_mem;
                end
            end
            MEM_OP_LH: begin
                mem_as_n   = 1'b0;
                miss_align = !aligned;
                if (aligned) begin
                    mem_data_to_gpr = half_sext;
                end
            end
            MEM_OP_LHU: begin
                mem_as_n   = 1'b0;
                miss_align = !aligned;
                if (aligned) begin
                    mem_data_to_gpr = half_zext;
                end
            end
            MEM_OP_LB: begin
                mem_as_n   = 1'b0;
                miss_align = !aligned;
                if (aligned) begin
                    mem_data_to_gpr = byte_sext;
                end
            end
            MEM_OP_LBU: begin
                mem_as_n   = 1'b0;
                miss_align = !aligned;
                if (aligned) begin
                    mem_data_to_gpr = byte_zext;
                end
            end
            MEM_OP_SW: begin
                mem_as_n   = 1'b0;
                rw         = BUS_WRITE;
                miss_align = !aligned;      // load result stays zero
            end
            default: begin
                mem_as_n = 1'b1;            // nop, no access
            end
        endcase
    end

endmodule

//--- logic/mem_stage_pkg.sv
package mem_stage_pkg;

    // operation code from the decoder
    typedef enum logic [2:0] {
        MEM_OP_NOP = 3'd0,  // no memory access
        MEM_OP_LW  = 3'd1,  // load word
        MEM_OP_LH  = 3'd2,  // load halfword, sign extended
        MEM_OP_LHU = 3'd3,  // load halfword, zero extended
        MEM_OP_LB  = 3'd4,  // load byte, sign extended
        MEM_OP_LBU = 3'd5,  // load byte, zero extended
        MEM_OP_SW  = 3'd6   // store word
    } mem_op_e;

    // direction of the bus access
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_dir_e;

endpackage

//--- logic/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// data word and register width
`define DATA_WIDTH 32

// byte address minus the two offset bits
`define WORD_ADDR_WIDTH 30

// address bits decoded by the ram, 256 words
`define RAM_DEPTH_LOG2 8

// extra cycles before the ram acks
`define RAM_WAIT_STATES 1

`endif
